// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_gpif
RTL_TOP    := gpif
FILELIST   := sim.f
FLAGS      := --binary --timing --timescale 1ns/1ps -j 0
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/1ps
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim.f ====
source/gpif_pkg.sv
source/fifo_sync.sv
source/fifo19_to_fifo36.sv
source/fifo36_to_fifo19.sv
source/gpif_wr.sv
source/gpif_rd.sv
source/fifo_to_wb.sv
source/gpif.sv
tests/tb_clock_gen.sv
tests/tb_gpif.sv

// ==== source/fifo19_to_fifo36.sv ====
// Stream packer; joins pairs of 18-bit items into one little-endian 36-bit item
`timescale 1ns/1ps
`default_nettype none

module fifo19_to_fifo36 (
   input  wire logic              gpif_clk,
   input  wire logic              rst_n_i,
   input  wire gpif_pkg::fifo18_t f19_data_i,
   input  wire logic              f19_src_rdy_i,
   output logic                   f19_dst_rdy_o,
   output gpif_pkg::fifo36_t      f36_data_o,
   output logic                   f36_src_rdy_o,
   input  wire logic              f36_dst_rdy_i
);
   import gpif_pkg::*;

   logic half, in_xfer, out_xfer;

   // Staging may start while the finished item leaves at the same edge
   assign f19_dst_rdy_o = ~f36_src_rdy_o | f36_dst_rdy_i;
   assign in_xfer       = f19_src_rdy_i & f19_dst_rdy_o;
   assign out_xfer      = f36_src_rdy_o & f36_dst_rdy_i;

   always_ff @(posedge gpif_clk) begin
      if (!rst_n_i) begin
         half          <= 1'b0;
         f36_src_rdy_o <= 1'b0;
      end else begin
         if (in_xfer && (half || f19_data_i.eof))
            f36_src_rdy_o <= 1'b1;
         else if (out_xfer)
            f36_src_rdy_o <= 1'b0;
         if (in_xfer)
            half <= ~half & ~f19_data_i.eof;
      end
   end

   // Low half first; eof on the low half leaves the high half empty
   always_ff @(posedge gpif_clk) begin
      if (in_xfer && !half) begin
         f36_data_o.data[15:0]  <= f19_data_i.data;
         f36_data_o.data[31:16] <= '0;
         f36_data_o.sof         <= f19_data_i.sof;
         f36_data_o.eof         <= f19_data_i.eof;
         f36_data_o.occ         <= f19_data_i.eof ? OCC_LOW : OCC_FULL;
      end else if (in_xfer) begin
         f36_data_o.data[31:16] <= f19_data_i.data;
         f36_data_o.eof         <= f19_data_i.eof;
         f36_data_o.occ         <= OCC_FULL;
      end
   end

endmodule

`default_nettype wire

// ==== source/fifo36_to_fifo19.sv ====
// Stream unpacker; splits 36-bit items into 18-bit items, low half first
`timescale 1ns/1ps
`default_nettype none

module fifo36_to_fifo19 (
   input  wire logic              gpif_clk,
   input  wire logic              rst_n_i,
   input  wire gpif_pkg::fifo36_t f36_data_i,
   input  wire logic              f36_src_rdy_i,
   output logic                   f36_dst_rdy_o,
   output gpif_pkg::fifo18_t      f19_data_o,
   input  wire logic              f19_dst_rdy_i,
   output logic                   f19_src_rdy_o
);
   import gpif_pkg::*;

   logic hi, last;

   // Low-only items skip the high half
   assign last = hi | (f36_data_i.occ == OCC_LOW);

   assign f19_src_rdy_o = f36_src_rdy_i;
   assign f36_dst_rdy_o = f19_dst_rdy_i & last;

   assign f19_data_o = '{eof:  f36_data_i.eof & last,
                         sof:  f36_data_i.sof & ~hi,
                         data: hi ? f36_data_i.data[31:16] : f36_data_i.data[15:0]};

   always_ff @(posedge gpif_clk) begin
      if (!rst_n_i)
         hi <= 1'b0;
      else if (f19_src_rdy_o && f19_dst_rdy_i)
         hi <= ~last;
   end

endmodule

`default_nettype wire

// ==== source/fifo_sync.sv ====
// First-word-fall-through FIFO of 36-bit stream items, used on both the TX and RX paths
`timescale 1ns/1ps
`default_nettype none

module fifo_sync #(
   parameter int DEPTH = 16
) (
   input  wire logic              gpif_clk,
   input  wire logic              rst_n_i,
   input  wire gpif_pkg::fifo36_t data_i,
   input  wire logic              src_rdy_i,
   output logic                   dst_rdy_o,
   output gpif_pkg::fifo36_t      data_o,
   output logic                   src_rdy_o,
   input  wire logic              dst_rdy_i
);
   import gpif_pkg::*;

   fifo36_t                    mem [DEPTH];
   logic [$clog2(DEPTH)-1:0]   wr_ptr, rd_ptr;
   logic [$clog2(DEPTH):0]     count, cnt_nxt;
   logic                       push, pop;

   assign push      = src_rdy_i & dst_rdy_o;
   assign pop       = src_rdy_o & dst_rdy_i;
   assign src_rdy_o = (count != '0);
   assign data_o    = mem[rd_ptr];

   always_comb begin
      cnt_nxt = count;
      if (push && !pop)
         cnt_nxt = count + 1'b1;
      else if (pop && !push)
         cnt_nxt = count - 1'b1;
   end

   // Ready is held low for the first cycle out of reset
   always_ff @(posedge gpif_clk) begin
      if (!rst_n_i) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         count     <= '0;
         dst_rdy_o <= 1'b0;
      end else begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         count     <= cnt_nxt;
         dst_rdy_o <= (cnt_nxt != DEPTH[$clog2(DEPTH):0]);
      end
   end

   always_ff @(posedge gpif_clk) begin
      if (push)
         mem[wr_ptr] <= data_i;
   end

endmodule

`default_nettype wire

// ==== source/fifo_to_wb.sv ====
// Control packet engine; runs each packet as one Wishbone single access and returns a response
`timescale 1ns/1ps
`default_nettype none

module fifo_to_wb (
   input  wire logic                 gpif_clk,
   input  wire logic                 rst_n_i,
   input  wire gpif_pkg::fifo18_t    data_i,
   input  wire logic                 src_rdy_i,
   output logic                      dst_rdy_o,
   output gpif_pkg::fifo18_t         data_o,
   output logic                      src_rdy_o,
   input  wire logic                 dst_rdy_i,
   output gpif_pkg::wb_m2s_t         wb_m2s_o,
   input  wire gpif_pkg::gpif_word_t wb_dat_i,
   input  wire logic                 wb_ack_i
);
   import gpif_pkg::*;

   typedef enum logic [2:0] {
      IDLE_HDR,
      ADDR,
      WDATA,
      BUS,
      RESP_HDR,
      RESP_DATA
   } state_t;

   state_t                state;
   gpif_word_t            hdr, wdat, rdata;
   wb_adr_t               adr;
   logic [RESP_CNT_W-1:0] resp_cnt;
   logic                  in_xfer, out_xfer, resp_last, busy;

   assign dst_rdy_o = (state == IDLE_HDR) || (state == ADDR) || (state == WDATA);
   assign src_rdy_o = (state == RESP_HDR) || (state == RESP_DATA);
   assign in_xfer   = src_rdy_i & dst_rdy_o;
   assign out_xfer  = src_rdy_o & dst_rdy_i;
   assign resp_last = (resp_cnt == RESP_CNT_W'(RESP_PKT_WORDS - 1));
   assign busy      = (state == BUS);

   // Header echoed first, then the access data
   assign data_o = '{eof:  resp_last,
                     sof:  (state == RESP_HDR),
                     data: (state == RESP_HDR) ? hdr : rdata};

   assign wb_m2s_o = '{adr: adr,
                       dat: wdat,
                       sel: 2'b11,
                       we:  hdr[CTRL_WE_BIT],
                       cyc: busy,
                       stb: busy};

   ////////////////////////////////////////////////////////////
   // Packet FSM
   always_ff @(posedge gpif_clk) begin
      if (!rst_n_i) begin
         state    <= IDLE_HDR;
         resp_cnt <= '0;
      end else begin
         case (state)
            // Words outside a packet are dropped until the next sof
            IDLE_HDR:  if (in_xfer && data_i.sof) state <= ADDR;
            // Short packet, back to hunting for a header
            ADDR:      if (in_xfer) state <= data_i.eof ? IDLE_HDR : WDATA;
            WDATA:     if (in_xfer) state <= BUS;
            BUS: begin
               if (wb_ack_i) begin
                  resp_cnt <= '0;
                  state    <= RESP_HDR;
               end
            end
            RESP_HDR: begin
               if (out_xfer) begin
                  resp_cnt <= resp_cnt + 1'b1;
                  state    <= RESP_DATA;
               end
            end
            RESP_DATA: begin
               if (out_xfer) begin
                  resp_cnt <= resp_cnt + 1'b1;
                  if (resp_last)
                     state <= IDLE_HDR;
               end
            end
            default:   state <= IDLE_HDR;
         endcase
      end
   end

   // Packet fields and the read result
   always_ff @(posedge gpif_clk) begin
      if (state == IDLE_HDR && in_xfer && data_i.sof)
         hdr <= data_i.data;
      if (state == ADDR && in_xfer)
         adr <= data_i.data;
      if (state == WDATA && in_xfer)
         wdat <= data_i.data;
      if (busy && wb_ack_i)
         rdata <= hdr[CTRL_WE_BIT] ? wdat : wb_dat_i;
   end

endmodule

`default_nettype wire

// ==== source/gpif.sv ====
// Top level of the GPIF host bridge; connect the host bus, Wishbone master and sample streams
`timescale 1ns/1ps
`default_nettype none

module gpif (
   input  wire logic                 gpif_clk,
   input  wire logic                 rst_n_i,
   inout  wire gpif_pkg::gpif_word_t gpif_d_io,
   input  wire logic [3:0]           gpif_ctl_i,
   output logic [3:0]                gpif_rdy_o,
   output gpif_pkg::wb_m2s_t         wb_m2s_o,
   input  wire gpif_pkg::gpif_word_t wb_dat_i,
   input  wire logic                 wb_ack_i,
   output gpif_pkg::fifo36_t         tx_data_o,
   output logic                      tx_src_rdy_o,
   input  wire logic                 tx_dst_rdy_i,
   input  wire gpif_pkg::fifo36_t    rx_data_i,
   input  wire logic                 rx_src_rdy_i,
   output logic                      rx_dst_rdy_o
);
   import gpif_pkg::*;

   logic       wr, rd, oe, ep;
   logic       cf, ce, df, de;
   gpif_word_t rd_word;

   fifo18_t tx18_data, ctrl_data, rx18_data, resp_data;
   logic    tx18_src_rdy, tx18_dst_rdy, ctrl_src_rdy, ctrl_dst_rdy;
   logic    rx18_src_rdy, rx18_dst_rdy, resp_src_rdy, resp_dst_rdy;
   fifo36_t tx36_data, rx36_data;
   logic    tx36_src_rdy, tx36_dst_rdy, rx36_src_rdy, rx36_dst_rdy;

   // Host strobes
   assign wr = gpif_ctl_i[0];
   assign rd = gpif_ctl_i[1];
   assign oe = gpif_ctl_i[2];
   assign ep = gpif_ctl_i[3];

   assign gpif_rdy_o = {cf, ce, df, de};
   assign gpif_d_io  = oe ? rd_word : 'z;

   ////////////////////////////////////////////////////////////
   // TX side
   gpif_wr gpif_wr (
      .gpif_clk, .rst_n_i,
      .gpif_data_i(gpif_d_io), .gpif_wr_i(wr), .gpif_ep_i(ep),
      .full_d_o(df), .full_c_o(cf),
      .data_o(tx18_data), .src_rdy_o(tx18_src_rdy), .dst_rdy_i(tx18_dst_rdy),
      .ctrl_o(ctrl_data), .ctrl_src_rdy_o(ctrl_src_rdy), .ctrl_dst_rdy_i(ctrl_dst_rdy));

   fifo19_to_fifo36 f18_to_f36 (
      .gpif_clk, .rst_n_i,
      .f19_data_i(tx18_data), .f19_src_rdy_i(tx18_src_rdy), .f19_dst_rdy_o(tx18_dst_rdy),
      .f36_data_o(tx36_data), .f36_src_rdy_o(tx36_src_rdy), .f36_dst_rdy_i(tx36_dst_rdy));

   fifo_sync #(.DEPTH(16)) tx_fifo (
      .gpif_clk, .rst_n_i,
      .data_i(tx36_data), .src_rdy_i(tx36_src_rdy), .dst_rdy_o(tx36_dst_rdy),
      .data_o(tx_data_o), .src_rdy_o(tx_src_rdy_o), .dst_rdy_i(tx_dst_rdy_i));

   ////////////////////////////////////////////////////////////
   // RX side
   fifo_sync #(.DEPTH(16)) rx_fifo (
      .gpif_clk, .rst_n_i,
      .data_i(rx_data_i), .src_rdy_i(rx_src_rdy_i), .dst_rdy_o(rx_dst_rdy_o),
      .data_o(rx36_data), .src_rdy_o(rx36_src_rdy), .dst_rdy_i(rx36_dst_rdy));

   fifo36_to_fifo19 f36_to_f18 (
      .gpif_clk, .rst_n_i,
      .f36_data_i(rx36_data), .f36_src_rdy_i(rx36_src_rdy), .f36_dst_rdy_o(rx36_dst_rdy),
      .f19_data_o(rx18_data), .f19_src_rdy_o(rx18_src_rdy), .f19_dst_rdy_i(rx18_dst_rdy));

   gpif_rd gpif_rd (
      .gpif_clk, .rst_n_i,
      .gpif_data_o(rd_word), .gpif_rd_i(rd), .gpif_ep_i(ep),
      .empty_d_o(de), .empty_c_o(ce),
      .data_i(rx18_data), .src_rdy_i(rx18_src_rdy), .dst_rdy_o(rx18_dst_rdy),
      .resp_i(resp_data), .resp_src_rdy_i(resp_src_rdy), .resp_dst_rdy_o(resp_dst_rdy));

   ////////////////////////////////////////////////////////////
   // Control endpoint to Wishbone
   fifo_to_wb fifo_to_wb (
      .gpif_clk, .rst_n_i,
      .data_i(ctrl_data), .src_rdy_i(ctrl_src_rdy), .dst_rdy_o(ctrl_dst_rdy),
      .data_o(resp_data), .src_rdy_o(resp_src_rdy), .dst_rdy_i(resp_dst_rdy),
      .wb_m2s_o, .wb_dat_i, .wb_ack_i);

endmodule

`default_nettype wire

// ==== source/gpif_pkg.sv ====
// Shared bus widths, stream framing structs, Wishbone bundle and control packet constants
`default_nettype none

package gpif_pkg;

   // Plain vectors with a meaning of their own
   typedef logic [15:0] gpif_word_t;
   typedef logic [15:0] wb_adr_t;

   // 18-bit stream item, one bus word with framing
   typedef struct packed {
      logic       eof;
      logic       sof;
      gpif_word_t data;
   } fifo18_t;

   // 36-bit stream item, two bus words, low half first
   typedef struct packed {
      logic [1:0]  occ;
      logic        eof;
      logic        sof;
      logic [31:0] data;
   } fifo36_t;

   // Wishbone master outputs
   typedef struct packed {
      wb_adr_t    adr;
      gpif_word_t dat;
      logic [1:0] sel;
      logic       we;
      logic       cyc;
      logic       stb;
   } wb_m2s_t;

   // occ encodings
   localparam logic [1:0] OCC_FULL = 2'd0;
   localparam logic [1:0] OCC_LOW  = 2'd1;

   // Control packet: header, address, write data
   localparam int CTRL_PKT_WORDS = 3;
   // Response packet: header, data
   localparam int RESP_PKT_WORDS = 2;
   localparam int CTRL_WE_BIT    = 15;
   localparam int DATA_LEN_BITS  = 16;

   localparam int CTRL_CNT_W = $clog2(CTRL_PKT_WORDS);
   localparam int RESP_CNT_W = $clog2(RESP_PKT_WORDS);

endpackage

`default_nettype wire

// ==== source/gpif_rd.sv ====
// Host read side; shows the head word of the selected endpoint and pops it on read strobes
`timescale 1ns/1ps
`default_nettype none

module gpif_rd (
   input  wire logic                 gpif_clk,
   input  wire logic                 rst_n_i,
   output gpif_pkg::gpif_word_t      gpif_data_o,
   input  wire logic                 gpif_rd_i,
   input  wire logic                 gpif_ep_i,
   output logic                      empty_d_o,
   output logic                      empty_c_o,
   input  wire gpif_pkg::fifo18_t    data_i,
   input  wire logic                 src_rdy_i,
   output logic                      dst_rdy_o,
   input  wire gpif_pkg::fifo18_t    resp_i,
   input  wire logic                 resp_src_rdy_i,
   output logic                      resp_dst_rdy_o
);

   logic d_pop, c_pop;

   // EP 1 reads responses, EP 0 reads sample data
   assign gpif_data_o = gpif_ep_i ? resp_i.data : data_i.data;

   // Reads of an empty endpoint are dropped
   assign dst_rdy_o      = gpif_rd_i & ~gpif_ep_i & ~empty_d_o;
   assign resp_dst_rdy_o = gpif_rd_i & gpif_ep_i & ~empty_c_o;

   assign d_pop = dst_rdy_o & src_rdy_i;
   assign c_pop = resp_dst_rdy_o & resp_src_rdy_i;

   // A pop hides the flag for one cycle while the next head settles
   always_ff @(posedge gpif_clk) begin
      if (!rst_n_i) begin
         empty_d_o <= 1'b1;
         empty_c_o <= 1'b1;
      end else begin
         empty_d_o <= ~src_rdy_i | d_pop;
         empty_c_o <= ~resp_src_rdy_i | c_pop;
      end
   end

endmodule

`default_nettype wire

// ==== source/gpif_wr.sv ====
// Host write side; samples bus words, frames data and control packets, holds one word per endpoint
`timescale 1ns/1ps
`default_nettype none

module gpif_wr (
   input  wire logic                 gpif_clk,
   input  wire logic                 rst_n_i,
   input  wire gpif_pkg::gpif_word_t gpif_data_i,
   input  wire logic                 gpif_wr_i,
   input  wire logic                 gpif_ep_i,
   output logic                      full_d_o,
   output logic                      full_c_o,
   output gpif_pkg::fifo18_t         data_o,
   output logic                      src_rdy_o,
   input  wire logic                 dst_rdy_i,
   output gpif_pkg::fifo18_t         ctrl_o,
   output logic                      ctrl_src_rdy_o,
   input  wire logic                 ctrl_dst_rdy_i
);
   import gpif_pkg::*;

   logic                     wr_d, wr_c;
   logic                     d_first, d_eof, c_eof;
   logic [DATA_LEN_BITS-1:0] d_rem;
   logic [CTRL_CNT_W-1:0]    c_cnt;

   // Host sees full whenever the endpoint register holds a word
   assign full_d_o = src_rdy_o;
   assign full_c_o = ctrl_src_rdy_o;

   // Writes to a full endpoint are dropped
   assign wr_d = gpif_wr_i & ~gpif_ep_i & ~full_d_o;
   assign wr_c = gpif_wr_i & gpif_ep_i & ~full_c_o;

   // Data framing, first word is the length in words including itself
   assign d_first = (d_rem == '0);
   assign d_eof   = d_first ? (gpif_data_i <= 16'd1) : (d_rem == DATA_LEN_BITS'(1));

   // Control framing is a fixed word count
   assign c_eof = (c_cnt == CTRL_CNT_W'(CTRL_PKT_WORDS - 1));

   always_ff @(posedge gpif_clk) begin
      if (!rst_n_i) begin
         src_rdy_o      <= 1'b0;
         ctrl_src_rdy_o <= 1'b0;
         d_rem          <= '0;
         c_cnt          <= '0;
      end else begin
         src_rdy_o      <= wr_d | (src_rdy_o & ~dst_rdy_i);
         ctrl_src_rdy_o <= wr_c | (ctrl_src_rdy_o & ~ctrl_dst_rdy_i);
         if (wr_d) begin
            if (d_eof)
               d_rem <= '0;
            else if (d_first)
               d_rem <= gpif_data_i - 1'b1;
            else
               d_rem <= d_rem - 1'b1;
         end
         if (wr_c)
            c_cnt <= c_eof ? '0 : c_cnt + 1'b1;
      end
   end

   // Endpoint output registers
   always_ff @(posedge gpif_clk) begin
      if (wr_d)
         data_o <= '{eof: d_eof, sof: d_first, data: gpif_data_i};
      if (wr_c)
         ctrl_o <= '{eof: c_eof, sof: (c_cnt == '0), data: gpif_data_i};
   end

endmodule

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
// Testbench clock and reset source; 8 ns clock, reset held low for the first 4 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
   output logic clk_o,
   output logic rst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #4 clk_o = ~clk_o;
   end

   // Synchronous reset, released on a rising edge
   initial begin
      rst_n_o = 1'b0;
      repeat (4) @(posedge clk_o);
      rst_n_o <= 1'b1;
   end

endmodule

`default_nettype wire

// ==== tests/tb_gpif.sv ====
// Testbench for the GPIF bridge; runs a table of host bus tests against the DUT and its models
`timescale 1ns/1ps
`default_nettype none

module tb_gpif;
   import gpif_pkg::*;

   localparam int N_TESTS = 6;
   localparam int TIMEOUT = 4000;
   localparam int K_TX    = 0;
   localparam int K_RX    = 1;
   localparam int K_CTRL  = 2;
   localparam int K_BP    = 3;
   // Flag positions in gpif_rdy_o
   localparam int RDY_DE  = 0;
   localparam int RDY_DF  = 1;
   localparam int RDY_CE  = 2;
   localparam int RDY_CF  = 3;

   logic            clk, rst_n;
   wire gpif_word_t gpif_d;
   gpif_word_t      host_d;
   logic            host_drv;
   logic [3:0]      gpif_ctl, gpif_rdy;
   wb_m2s_t         wb_m2s;
   gpif_word_t      wb_dat = '0;
   logic            wb_ack = 1'b0;
   fifo36_t         tx_data, rx_data;
   logic            tx_src_rdy, rx_src_rdy, rx_dst_rdy;
   logic            tx_dst_rdy = 1'b0;
   logic            rand_rdy = 1'b0;

   gpif_word_t      mem [64];
   logic [1:0]      ack_cnt;
   int              wb_writes;
   wb_adr_t         last_adr;
   gpif_word_t      last_dat;
   logic [1:0]      last_sel;
   fifo36_t         tx_q [$];
   gpif_word_t      host_words [$];
   fifo36_t         exp_items [$];

   // Test table
   string           t_name [N_TESTS];
   int              t_kind [N_TESTS];
   logic            t_ep [N_TESTS];
   int              t_nin [N_TESTS];
   int              t_nexp [N_TESTS];
   logic [35:0]     t_in [N_TESTS][4];
   logic [35:0]     t_exp [N_TESTS][3];
   int              test_errs, passes, fails;

   tb_clock_gen clock_gen (.clk_o(clk), .rst_n_o(rst_n));

   // Host side of the shared data bus
   assign gpif_d = host_drv ? host_d : 'z;

   gpif DUT (
      .gpif_clk(clk), .rst_n_i(rst_n),
      .gpif_d_io(gpif_d), .gpif_ctl_i(gpif_ctl), .gpif_rdy_o(gpif_rdy),
      .wb_m2s_o(wb_m2s), .wb_dat_i(wb_dat), .wb_ack_i(wb_ack),
      .tx_data_o(tx_data), .tx_src_rdy_o(tx_src_rdy), .tx_dst_rdy_i(tx_dst_rdy),
      .rx_data_i(rx_data), .rx_src_rdy_i(rx_src_rdy), .rx_dst_rdy_o(rx_dst_rdy));

   ////////////////////////////////////////////////////////////
   // Wishbone slave that acks two cycles after stb, with a 64-word memory
   always @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < 64; i++)
            mem[i] <= gpif_word_t'(i * 3);
         ack_cnt   <= '0;
         wb_ack    <= 1'b0;
         wb_writes <= 0;
         last_sel  <= '0;
      end else if (!(wb_m2s.cyc && wb_m2s.stb) || wb_ack) begin
         ack_cnt <= '0;
         wb_ack  <= 1'b0;
      end else if (ack_cnt == 2'd1) begin
         wb_ack   <= 1'b1;
         last_sel <= wb_m2s.sel;
         if (wb_m2s.we) begin
            mem[wb_m2s.adr[5:0]] <= wb_m2s.dat;
            wb_writes            <= wb_writes + 1;
            last_adr             <= wb_m2s.adr;
            last_dat             <= wb_m2s.dat;
         end else begin
            wb_dat <= mem[wb_m2s.adr[5:0]];
         end
      end else begin
         ack_cnt <= ack_cnt + 1'b1;
      end
   end

   // TX sink with sparse ready in the back-pressure test
   always @(posedge clk) begin
      tx_dst_rdy <= rand_rdy ? (($urandom % 16) == 0) : 1'b1;
   end

   always @(negedge clk) begin
      if (rst_n && tx_src_rdy && tx_dst_rdy)
         tx_q.push_back(tx_data);
   end

   ////////////////////////////////////////////////////////////
   // Host bus and stream tasks

   task automatic add_test(input int i, input string name, input int kind, input logic ep,
                           input int nin, input logic [35:0] in0, in1, in2, in3,
                           input int nexp, input logic [35:0] e0, e1, e2);
      t_name[i]   = name;
      t_kind[i]   = kind;
      t_ep[i]     = ep;
      t_nin[i]    = nin;
      t_nexp[i]   = nexp;
      t_in[i][0]  = in0;
      t_in[i][1]  = in1;
      t_in[i][2]  = in2;
      t_in[i][3]  = in3;
      t_exp[i][0] = e0;
      t_exp[i][1] = e1;
      t_exp[i][2] = e2;
   endtask

   // Word is taken at the edge after a negedge that saw the full flag low
   task automatic write_word(input logic ep, input gpif_word_t w, output bit ok);
      ok = 1'b0;
      for (int t = 0; t < TIMEOUT && !ok; t++) begin
         @(posedge clk);
         gpif_ctl <= {ep, 3'b001};
         host_d   <= w;
         host_drv <= 1'b1;
         @(negedge clk);
         ok = !gpif_rdy[ep ? RDY_CF : RDY_DF];
      end
   endtask

   task automatic read_word(input logic ep, output gpif_word_t w, output bit ok);
      ok = 1'b0;
      w  = '0;
      for (int t = 0; t < TIMEOUT && !ok; t++) begin
         @(posedge clk);
         host_drv <= 1'b0;
         gpif_ctl <= {ep, 3'b110};
         @(negedge clk);
         ok = !gpif_rdy[ep ? RDY_CE : RDY_DE];
         w  = gpif_d;
      end
   endtask

   task automatic push_rx(input fifo36_t item, output bit ok);
      ok = 1'b0;
      for (int t = 0; t < TIMEOUT && !ok; t++) begin
         @(posedge clk);
         rx_data    <= item;
         rx_src_rdy <= 1'b1;
         @(negedge clk);
         ok = rx_dst_rdy;
      end
   endtask

   task automatic bus_idle();
      @(posedge clk);
      gpif_ctl   <= '0;
      host_drv   <= 1'b0;
      rx_src_rdy <= 1'b0;
   endtask

   task automatic wait_tx(input int n, output bit ok);
      int t;
      t = 0;
      while (tx_q.size() < n && t < TIMEOUT) begin
         @(negedge clk);
         t++;
      end
      ok = (tx_q.size() >= n);
   endtask

   // Frames by the length word and packs pairs low half first
   function automatic void frame_items();
      int      rem;
      logic    sof, eof, half;
      fifo36_t item;
      rem  = 0;
      half = 1'b0;
      item = '0;
      foreach (host_words[k]) begin
         sof = (rem == 0);
         if (sof)
            rem = int'(host_words[k]);
         eof = (rem <= 1);
         rem = eof ? 0 : rem - 1;
         if (!half) begin
            item = '{occ: eof ? OCC_LOW : OCC_FULL, eof: eof, sof: sof,
                     data: {16'h0000, host_words[k]}};
            if (eof)
               exp_items.push_back(item);
            half = !eof;
         end else begin
            item.data[31:16] = host_words[k];
            item.eof         = eof;
            exp_items.push_back(item);
            half = 1'b0;
         end
      end
   endfunction

   task automatic run_test(input int i);
      gpif_word_t w;
      fifo36_t    e, a;
      int         base, writes0, exp_writes, t, flag;
      bit         ok;
      test_errs = 0;
      ok        = 1'b1;
      base      = tx_q.size();
      writes0   = wb_writes;
      host_words.delete();
      exp_items.delete();
      for (int k = 0; k < t_nexp[i]; k++)
         exp_items.push_back(t_exp[i][k]);
      if (t_kind[i] == K_BP) begin
         // Table holds packet lengths and the payload is random
         for (int p = 0; p < t_nin[i]; p++) begin
            host_words.push_back(t_in[i][p][15:0]);
            for (int k = 1; k < int'(t_in[i][p][15:0]); k++)
               host_words.push_back(gpif_word_t'($urandom));
         end
         frame_items();
      end else if (t_kind[i] != K_RX) begin
         for (int k = 0; k < t_nin[i]; k++)
            host_words.push_back(t_in[i][k][15:0]);
      end
      rand_rdy <= (t_kind[i] == K_BP);

      foreach (host_words[k])
         if (ok)
            write_word(t_ep[i], host_words[k], ok);
      if (t_kind[i] == K_RX)
         for (int k = 0; k < t_nin[i] && ok; k++)
            push_rx(t_in[i][k], ok);
      bus_idle();
      if (!ok) begin
         $display("Timeout in %s, the DUT never accepted the stimulus", t_name[i]);
         test_errs++;
      end

      if (ok && (t_kind[i] == K_TX || t_kind[i] == K_BP)) begin
         wait_tx(base + exp_items.size(), ok);
         if (!ok) begin
            $display("Timeout in %s, only %0d of %0d TX items arrived", t_name[i],
                     tx_q.size() - base, exp_items.size());
            test_errs++;
         end
         for (int k = 0; k < exp_items.size() && ok; k++) begin
            e = exp_items[k];
            a = tx_q[base + k];
            if (a.occ !== e.occ || a.eof !== e.eof || a.sof !== e.sof ||
                a.data[15:0] !== e.data[15:0] ||
                (e.occ == OCC_FULL && a.data[31:16] !== e.data[31:16])) begin
               $display("Fail %s item %0d: expected %h actual %h", t_name[i], k, e, a);
               test_errs++;
            end
         end
      end else if (ok) begin
         // RX data or control responses come back over the bus
         foreach (exp_items[k]) begin
            if (ok)
               read_word(t_ep[i], w, ok);
            if (!ok) begin
               $display("Timeout in %s, read word %0d never became ready", t_name[i], k);
               test_errs++;
            end else if (w !== exp_items[k].data[15:0]) begin
               $display("Fail %s word %0d: expected %h actual %h", t_name[i], k,
                        exp_items[k].data[15:0], w);
               test_errs++;
            end
         end
         bus_idle();
         // Empty flag of the endpoint that was read
         flag = t_ep[i] ? RDY_CE : RDY_DE;
         t    = 0;
         while (!gpif_rdy[flag] && t < TIMEOUT) begin
            @(negedge clk);
            t++;
         end
         if (!gpif_rdy[flag]) begin
            $display("Fail %s: %s did not return high after the last word", t_name[i],
                     t_ep[i] ? "CE" : "DE");
            test_errs++;
         end
      end

      if (t_kind[i] == K_CTRL) begin
         exp_writes = host_words[0][CTRL_WE_BIT] ? 1 : 0;
         if (wb_writes - writes0 != exp_writes) begin
            $display("Fail %s Wishbone writes: expected %0d actual %0d", t_name[i],
                     exp_writes, wb_writes - writes0);
            test_errs++;
         end else if (exp_writes == 1 &&
                      {last_adr, last_dat} !== {host_words[1], host_words[2]}) begin
            $display("Fail %s Wishbone write: expected %h actual %h", t_name[i],
                     {host_words[1], host_words[2]}, {last_adr, last_dat});
            test_errs++;
         end
         // Both byte lanes on every access
         if (last_sel !== 2'b11) begin
            $display("Fail %s Wishbone sel: expected %b actual %b", t_name[i],
                     2'b11, last_sel);
            test_errs++;
         end
      end
      rand_rdy <= 1'b0;

      if (test_errs == 0) begin
         passes++;
         $display("Test %s: passed", t_name[i]);
      end else begin
         fails++;
         $display("Test %s: failed with %0d errors", t_name[i], test_errs);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence
   initial begin
      int t;
      gpif_ctl   = '0;
      host_d     = '0;
      host_drv   = 1'b0;
      rx_data    = '0;
      rx_src_rdy = 1'b0;
      passes     = 0;
      fails      = 0;
      void'($urandom(32'h7173));

      // Items are {occ, eof, sof, data} and control words sit in the low 16 bits
      add_test(0, "even_data", K_TX, 1'b0, 4, 36'h0_0000_0004, 36'h0_0000_A1B2,
               36'h0_0000_C3D4, 36'h0_0000_E5F6, 2, 36'h1_A1B2_0004, 36'h2_E5F6_C3D4, '0);
      add_test(1, "odd_data", K_TX, 1'b0, 3, 36'h0_0000_0003, 36'h0_0000_1111,
               36'h0_0000_2222, '0, 2, 36'h1_1111_0003, 36'h6_0000_2222, '0);
      add_test(2, "rx_readback", K_RX, 1'b0, 2, 36'h1_BBBB_AAAA, 36'h6_DEAD_CCCC, '0, '0,
               3, 36'h0_0000_AAAA, 36'h0_0000_BBBB, 36'h0_0000_CCCC);
      add_test(3, "ctrl_write", K_CTRL, 1'b1, 3, 36'h0_0000_8012, 36'h0_0000_0005,
               36'h0_0000_5A5A, '0, 2, 36'h0_0000_8012, 36'h0_0000_5A5A, '0);
      // Memory holds address times 3
      add_test(4, "ctrl_read", K_CTRL, 1'b1, 3, 36'h0_0000_0007, 36'h0_0000_0021,
               36'h0_0000_0000, '0, 2, 36'h0_0000_0007, 36'(16'h0021 * 3), '0);
      add_test(5, "back_pressure", K_BP, 1'b0, 4, 36'd16, 36'd9, 36'd21, 36'd18,
               0, '0, '0, '0);

      t = 0;
      while (!rst_n && t < 20) begin
         @(posedge clk);
         t++;
      end
      if (!rst_n) begin
         $display("Reset was never released");
         fails++;
      end else begin
         for (int i = 0; i < N_TESTS; i++)
            run_test(i);
      end

      $display("Tests run %0d, passed %0d, failed %0d", passes + fails, passes, fails);
      if (fails == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire
